/* project.f */
+incdir+.
rv32i_types_pkg.sv
cacheline_adapter.sv
icache.sv
fetch_unit.sv
inst_queue.sv
cpu_frontend.sv
bmem_model.sv
tb_cpu_frontend.sv

/* run.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu_frontend \
    -f project.f \
    -o sim_cpu_frontend

./obj_dir/sim_cpu_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

/* tb_cpu_frontend.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module tb_cpu_frontend;

    localparam logic [31:0] SEED           = 32'h3b04_6a21;
    localparam logic [31:0] DATA_KEY       = 32'hA5A5_0000;
    localparam int          NUM_INSTS      = 300;
    localparam int          HOLD_AFTER     = 100;        // Dequeues before the stall
    localparam int          HOLD_CYCLES    = 60;
    localparam int          TIMEOUT_CYCLES = NUM_INSTS * 40;

    logic        clk;
    logic        rst;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    logic [63:0] bmem_rdata;
    logic        bmem_rvalid;
    logic        deq;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        iq_empty;

    integer      seed = SEED;
    int          err_count = 0;
    int          bmem_err_count;
    int          bmem_read_count;
    int          deq_count = 0;
    int          cycle_count = 0;
    logic [31:0] exp_pc;
    logic        rst_q = 1'b0;

    cpu_frontend i_dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .deq_i         (deq),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc),
        .iq_empty_o    (iq_empty)
    );

    bmem_model #(
        .SEED     (SEED),
        .DATA_KEY (DATA_KEY)
    ) i_bmem (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid),
        .err_count_o   (bmem_err_count),
        .read_count_o  (bmem_read_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s: expected %h, actual %h (time %0t)", name, expected, actual, $time);
        err_count++;
    endtask

    // Random dequeue strobes until the consumer has taken target entries
    task automatic dequeue_until(input int target);
        while (deq_count < target) begin
            deq = (($random(seed) & 3) != 0);
            @(posedge clk);
            #1;
        end
        deq = 1'b0;
    endtask

    // Waits for fetching to stop on a full queue
    task automatic wait_for_full_queue();
        while (!i_dut.iq_full) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Expected stream and bookkeeping
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        rst_q       <= rst;
        if (rst) begin
            exp_pc <= `FE_RESET_PC;
        end else if (deq && !iq_empty) begin
            exp_pc    <= exp_pc + 32'd4;
            deq_count <= deq_count + 1;
        end
    end

    // Covers reset and the first cycle after release
    assert property (@(posedge clk) rst_q |-> (!bmem_read && iq_empty))
        else begin
            $display("Reset state wrong: bmem_read_o=%b iq_empty_o=%b",
                     $sampled(bmem_read), $sampled(iq_empty));
            err_count++;
        end

    assert property (@(posedge clk) disable iff (rst)
        (deq && !iq_empty) |-> (inst_pc == exp_pc))
        else report_mismatch("pc_order", $sampled(exp_pc), $sampled(inst_pc));

    assert property (@(posedge clk) disable iff (rst)
        (deq && !iq_empty) |-> (inst == (inst_pc ^ DATA_KEY)))
        else report_mismatch("inst_data", $sampled(inst_pc) ^ DATA_KEY, $sampled(inst));

    assert property (@(posedge clk) disable iff (rst) i_dut.iq_full |-> !bmem_read)
        else begin
            $display("Burst read started while the instruction queue was full (time %0t)",
                     $time);
            err_count++;
        end

    initial begin : stimulus
        logic [31:0] last_fetch;
        logic [31:0] exp_reads;
        rst = 1'b1;
        deq = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        dequeue_until(HOLD_AFTER);
        wait_for_full_queue();                   // Consumer stalls until the queue backs up
        repeat (HOLD_CYCLES) @(posedge clk);     // Fetch stays paused while full
        #1;
        dequeue_until(NUM_INSTS);
        // Queue full means no fetch is in flight
        wait_for_full_queue();
        // DEPTH-1 entries wait in the queue behind the dequeued ones
        last_fetch = exp_pc + 32'(4 * (`FE_IQ_DEPTH - 2));
        exp_reads  = (last_fetch >> 5) - (`FE_RESET_PC >> 5) + 32'd1;
        assert (bmem_read_count == exp_reads)
            else report_mismatch("burst_count", exp_reads, bmem_read_count);
        $display("Errors: tb=%0d bmem=%0d, instructions=%0d, bursts=%0d, cycles=%0d",
                 err_count, bmem_err_count, deq_count, bmem_read_count, cycle_count);
        if (err_count == 0 && bmem_err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles with %0d of %0d instructions dequeued",
                 cycle_count, deq_count, NUM_INSTS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : tb_cpu_frontend

/* bmem_model.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module bmem_model #(
    parameter logic [31:0] SEED     = 32'h1,
    parameter logic [31:0] DATA_KEY = 32'h0
) (
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] bmem_addr_i,
    input  logic        bmem_read_i,
    output logic        bmem_ready_o,
    output logic [63:0] bmem_rdata_o,
    output logic        bmem_rvalid_o,

    output int          err_count_o,
    output int          read_count_o
);

    localparam int BEATS = `FE_BURST_BEATS;

    logic [31:0] pending [$];                        // Accepted burst addresses
    logic [31:0] exp_line;
    logic        read_q;
    logic        burst_open;
    int          beat_cnt;
    int          err_count = 0;
    int          read_count = 0;
    integer      ready_seed = SEED;
    integer      lat_seed = SEED ^ 32'h0f0f_0f0f;

    assign err_count_o  = err_count;
    assign read_count_o = read_count;

    task automatic flag_protocol_error(input string msg);
        $display("%s (time %0t)", msg, $time);
        err_count++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            read_q     <= 1'b0;
            burst_open <= 1'b0;
            beat_cnt   <= 0;
            exp_line   <= `FE_RESET_PC & ~32'h1f;
        end else begin
            read_q <= bmem_read_i;
            if (bmem_read_i) begin
                pending.push_back(bmem_addr_i);
                read_count <= read_count + 1;
                burst_open <= 1'b1;
                exp_line   <= exp_line + 32'd32;   // Fetch runs sequentially
            end
            if (bmem_rvalid_o) begin
                if (beat_cnt == BEATS - 1) begin
                    beat_cnt   <= 0;
                    burst_open <= 1'b0;
                end else begin
                    beat_cnt <= beat_cnt + 1;
                end
            end
        end
    end

    // Ready toggles at random, high three cycles in four
    initial begin
        bmem_ready_o = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            bmem_ready_o = rst ? 1'b1 : (({$random(ready_seed)} % 4) != 0);
        end
    end

    initial begin : burst_driver
        logic [31:0] base;
        logic [31:0] addr;
        int          delay;
        int          gap;
        bmem_rvalid_o = 1'b0;
        bmem_rdata_o  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (pending.size() > 0) begin
                base  = pending.pop_front();
                delay = {$random(lat_seed)} % 8;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                for (int k = 0; k < BEATS; k++) begin
                    gap = {$random(lat_seed)} % 3;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    addr          = base + 32'(k * 8);
                    bmem_rdata_o  = {(addr + 32'd4) ^ DATA_KEY, addr ^ DATA_KEY};
                    bmem_rvalid_o = 1'b1;
                    @(posedge clk);
                    #1;
                    bmem_rvalid_o = 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) bmem_read_i |-> bmem_ready_o)
        else flag_protocol_error("Burst read pulse sent while memory was not ready");

    assert property (@(posedge clk) disable iff (rst) bmem_read_i |-> !read_q)
        else flag_protocol_error("Burst read held high for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) bmem_read_i |-> !burst_open)
        else flag_protocol_error("New burst read before all beats of the last one returned");

    assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> (bmem_addr_i[4:0] == 5'd0))
        else flag_protocol_error("Burst address is not 32-byte aligned");

    assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> (bmem_addr_i == exp_line))
        else begin
            $display("[FAIL] burst_address: expected %h, actual %h",
                     $sampled(exp_line), $sampled(bmem_addr_i));
            err_count++;
        end

endmodule : bmem_model

/* cpu_frontend.sv */
`timescale 1ns/1ps

module cpu_frontend (
    input  logic                   clk,
    input  logic                   rst,

    // Burst memory
    output rv32i_types_pkg::word_t bmem_addr_o,
    output logic                   bmem_read_o,
    input  logic                   bmem_ready_i,
    input  logic [63:0]            bmem_rdata_i,
    input  logic                   bmem_rvalid_i,

    // Instruction consumer
    input  logic                   deq_i,
    output rv32i_types_pkg::word_t inst_o,
    output rv32i_types_pkg::word_t inst_pc_o,
    output logic                   iq_empty_o
);

    rv32i_types_pkg::word_t      ufp_addr;
    logic                        ufp_read;
    rv32i_types_pkg::word_t      ufp_rdata;
    logic                        ufp_resp;

    rv32i_types_pkg::word_t      dfp_addr;
    logic                        dfp_read;
    logic                        dfp_read_q;
    rv32i_types_pkg::cacheline_t dfp_rdata;
    logic                        dfp_resp;

    logic                        enq;
    rv32i_types_pkg::word_t      enq_pc;
    logic                        iq_full;

    // Captures dfp_read only once the burst is issued, so a stalled pulse waits
    always_ff @(posedge clk) begin
        if (rst) begin
            dfp_read_q <= 1'b0;
        end else begin
            dfp_read_q <= dfp_read && (dfp_read_q || bmem_ready_i);
        end
    end

    assign bmem_read_o = dfp_read && !dfp_read_q && bmem_ready_i;   // Rising edge
    assign bmem_addr_o = dfp_addr;

    fetch_unit i_fetch_unit (
        .clk        (clk),
        .rst        (rst),
        .iq_full_i  (iq_full),
        .ufp_resp_i (ufp_resp),
        .ufp_addr_o (ufp_addr),
        .ufp_read_o (ufp_read),
        .enq_o      (enq),
        .enq_pc_o   (enq_pc)
    );

    icache i_icache (
        .clk         (clk),
        .rst         (rst),
        .ufp_addr_i  (ufp_addr),
        .ufp_read_i  (ufp_read),
        .ufp_rdata_o (ufp_rdata),
        .ufp_resp_o  (ufp_resp),
        .dfp_addr_o  (dfp_addr),
        .dfp_read_o  (dfp_read),
        .dfp_rdata_i (dfp_rdata),
        .dfp_resp_i  (dfp_resp)
    );

    cacheline_adapter i_cacheline_adapter (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (dfp_rdata),
        .line_valid_o  (dfp_resp)
    );

    inst_queue #(
        .DATA_WIDTH (64)
    ) i_inst_queue (
        .clk     (clk),
        .rst     (rst),
        .wdata_i ({enq_pc, ufp_rdata}),                // PC in the upper half
        .enq_i   (enq),
        .deq_i   (deq_i),
        .rdata_o ({inst_pc_o, inst_o}),
        .full_o  (iq_full),
        .empty_o (iq_empty_o)
    );

endmodule : cpu_frontend

/* inst_queue.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module inst_queue #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = `FE_IQ_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic                  enq_i,
    input  logic                  deq_i,

    output logic [DATA_WIDTH-1:0] rdata_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    logic                  do_enq;
    logic                  do_deq;

    assign do_enq = enq_i && (count != CNT_W'(DEPTH));
    assign do_deq = deq_i && (count != '0);          // Dequeue on empty ignored

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    assign rdata_o = mem[rd_ptr];
    assign empty_o = (count == '0);

    // One slot kept back for the fetch in flight
    assign full_o  = (count >= CNT_W'(DEPTH - 1));

endmodule : inst_queue

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   iq_full_i,
    input  logic                   ufp_resp_i,

    output rv32i_types_pkg::word_t ufp_addr_o,
    output logic                   ufp_read_o,

    output logic                   enq_o,
    output rv32i_types_pkg::word_t enq_pc_o
);

    rv32i_types_pkg::word_t pc;
    logic                   req_open;
    logic                   resp;

    assign resp = req_open && ufp_resp_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `FE_RESET_PC;
            req_open <= 1'b0;
        end else begin
            if (resp) begin
                pc       <= pc + 32'd4;
                req_open <= 1'b0;                   // Reopen next cycle if room
            end else if (!req_open && !iq_full_i) begin
                req_open <= 1'b1;
            end
        end
    end

    // PC stays put while a request is open
    assign ufp_addr_o = pc;
    assign ufp_read_o = req_open;

    // Returned word belongs to the current PC
    assign enq_o    = resp;
    assign enq_pc_o = pc;

endmodule : fetch_unit

/* icache.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module icache (
    input  logic                        clk,
    input  logic                        rst,

    // Fetch side
    input  rv32i_types_pkg::word_t      ufp_addr_i,
    input  logic                        ufp_read_i,
    output rv32i_types_pkg::word_t      ufp_rdata_o,
    output logic                        ufp_resp_o,

    // Memory side
    output rv32i_types_pkg::word_t      dfp_addr_o,
    output logic                        dfp_read_o,
    input  rv32i_types_pkg::cacheline_t dfp_rdata_i,
    input  logic                        dfp_resp_i
);

    localparam int SETS     = `FE_ICACHE_SETS;
    localparam int OFFSET_W = $clog2(`FE_LINE_BYTES);
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;
    localparam int WSEL_W   = OFFSET_W - 2;

    rv32i_types_pkg::icache_state_t state;

    rv32i_types_pkg::cacheline_t data_arr [SETS];
    logic [TAG_W-1:0]            tag_arr  [SETS];
    logic [SETS-1:0]             valid;

    rv32i_types_pkg::word_t      req_addr;
    logic [TAG_W-1:0]            req_tag;
    logic [INDEX_W-1:0]          req_index;
    logic [WSEL_W-1:0]           req_wsel;

    logic                        accept;
    logic                        hit;
    rv32i_types_pkg::word_t      hit_word;
    rv32i_types_pkg::cacheline_t hit_line;

    assign req_tag   = req_addr[31:OFFSET_W+INDEX_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_wsel  = req_addr[OFFSET_W-1:2];

    // Read stays high during the resp cycle, so skip it then
    assign accept = (state == rv32i_types_pkg::IDLE) && ufp_read_i && !ufp_resp_o;

    assign hit_line = data_arr[req_index];
    assign hit      = valid[req_index] && (tag_arr[req_index] == req_tag);
    assign hit_word = hit_line[req_wsel*32 +: 32];

    // Controller
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= rv32i_types_pkg::IDLE;
            valid      <= '0;
            ufp_resp_o <= 1'b0;
        end else begin
            ufp_resp_o <= 1'b0;
            case (state)
                rv32i_types_pkg::IDLE: begin
                    if (accept) begin
                        state <= rv32i_types_pkg::COMPARE;
                    end
                end
                rv32i_types_pkg::COMPARE: begin
                    if (hit) begin
                        ufp_resp_o <= 1'b1;
                        state      <= rv32i_types_pkg::IDLE;
                    end else begin
                        state <= rv32i_types_pkg::ALLOCATE;         // Miss, fetch the line
                    end
                end
                rv32i_types_pkg::ALLOCATE: begin
                    if (dfp_resp_i) begin
                        valid[req_index] <= 1'b1;
                        state            <= rv32i_types_pkg::COMPARE; // Retry as a hit
                    end
                end
                default: begin
                    state <= rv32i_types_pkg::IDLE;
                end
            endcase
        end
    end

    // Request latch, read data and the line arrays
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= ufp_addr_i;
        end
        if ((state == rv32i_types_pkg::COMPARE) && hit) begin
            ufp_rdata_o <= hit_word;
        end
        if ((state == rv32i_types_pkg::ALLOCATE) && dfp_resp_i) begin
            data_arr[req_index] <= dfp_rdata_i;
            tag_arr[req_index]  <= req_tag;
        end
    end

    // Line-aligned fill request, held until the adapter answers
    assign dfp_read_o = (state == rv32i_types_pkg::ALLOCATE);
    assign dfp_addr_o = {req_addr[31:OFFSET_W], OFFSET_W'(0)};

endmodule : icache

/* cacheline_adapter.sv */
`timescale 1ns/1ps
`include "frontend_config.svh"

module cacheline_adapter (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [63:0]                bmem_rdata_i,
    input  logic                       bmem_rvalid_i,

    output rv32i_types_pkg::cacheline_t line_o,
    output logic                       line_valid_o
);

    localparam int BEATS  = `FE_BURST_BEATS;
    localparam int CNT_W  = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int LINE_W = `FE_LINE_BYTES * 8;

    logic [CNT_W-1:0]            beat_cnt;
    rv32i_types_pkg::cacheline_t line_q;
    logic                        last_beat;

    assign last_beat = bmem_rvalid_i && (beat_cnt == CNT_W'(BEATS - 1));

    // Beat counter and completion strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;
            if (last_beat) begin
                beat_cnt <= '0;                     // Ready for next burst
            end else if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Beats arrive low address first, shift in from the top
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:64]};
        end
    end

    assign line_o = line_q;

endmodule : cacheline_adapter

/* rv32i_types_pkg.sv */
`include "frontend_config.svh"

package rv32i_types_pkg;

    // Instruction cache controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE
    } icache_state_t;

    // One full cache line
    typedef logic [`FE_LINE_BYTES*8-1:0] cacheline_t;

    // Address or instruction word
    typedef logic [31:0] word_t;

endpackage : rv32i_types_pkg

/* frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// First fetch address after reset
`define FE_RESET_PC     32'h1eceb000

// Direct-mapped instruction cache geometry
`define FE_ICACHE_SETS  16
`define FE_LINE_BYTES   32

// 64-bit beats per burst, one burst fills one line
`define FE_BURST_BEATS  4

// Default instruction queue depth
`define FE_IQ_DEPTH     16

`endif
